// ==== blake2b_pipe.f ====
+incdir+.
blake2b_pkg.sv
blake2b_g.sv
blake2b_round_pipe.sv
blake2b_ingress.sv
blake2b_digest_fifo.sv
blake2b_pipe_top.sv
tb_blake2b.sv

// ==== Makefile ====
TOP := tb_blake2b

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f blake2b_pipe.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module blake2b_pipe_top -f blake2b_pipe.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tb_blake2b_model.svh ====
// Reference BLAKE2b compression of one final unkeyed block
// Fibonacci LFSR used for all random stimulus
`ifndef TB_BLAKE2B_MODEL_SVH
`define TB_BLAKE2B_MODEL_SVH

// Taps 32 22 2 1, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r          = {r[30:0], fb};  // Newest bit lands in bit 0
  end
  return r;
endfunction

// RFC 7693 initialization vector
function automatic logic [63:0] ref_iv(input int i);
  case (i)
    0:       return 64'h6a09e667f3bcc908;
    1:       return 64'hbb67ae8584caa73b;
    2:       return 64'h3c6ef372fe94f82b;
    3:       return 64'ha54ff53a5f1d36f1;
    4:       return 64'h510e527fade682d1;
    5:       return 64'h9b05688c2b3e6c1f;
    6:       return 64'h1f83d9abfb41bd6b;
    default: return 64'h5be0cd19137e2179;
  endcase
endfunction

// Message schedule entry i of round r, rows repeat every 10 rounds
function automatic logic [3:0] ref_sigma(input int r, input int i);
  logic [63:0] row;
  case (r % 10)
    0:       row = 64'h0123456789abcdef;
    1:       row = 64'hea489fd61c02b753;
    2:       row = 64'hb8c052fdae367194;
    3:       row = 64'h7931dcbe265a40f8;
    4:       row = 64'h905724afe1bc683d;
    5:       row = 64'h2c6a0b834d75fe19;
    6:       row = 64'hc51fed4a0763928b;
    7:       row = 64'hdb7ec13950f4862a;
    8:       row = 64'h6fe9b308c2d714a5;
    default: row = 64'ha2847615fb9e3cd0;
  endcase
  return row[63 - 4*i -: 4];  // Leftmost digit is entry 0
endfunction

function automatic logic [63:0] rotr64(input logic [63:0] x, input int n);
  return (x >> n) | (x << (64 - n));
endfunction

// Digest of a single last block of len bytes, chain value from params XOR IV
function automatic logic [511:0] ref_blake2b(input logic [1023:0] blk, input int len,
                                             input logic [511:0] params);
  logic [63:0]   v [16];
  logic [63:0]   m [16];
  logic [63:0]   h [8];
  logic [1023:0] pad;
  logic [511:0]  dig;
  int            a, b, c, d, g4;
  for (int i = 0; i < 128; i++) begin
    pad[8*i +: 8] = (i < len) ? blk[8*i +: 8] : 8'h00;  // Zero padding
  end
  for (int i = 0; i < 16; i++) begin
    m[i] = pad[64*i +: 64];
  end
  for (int i = 0; i < 8; i++) begin
    h[i]   = params[64*i +: 64] ^ ref_iv(i);
    v[i]   = h[i];
    v[i+8] = ref_iv(i);
  end
  v[12] = v[12] ^ 64'(len);  // Low counter word, high word stays zero
  v[14] = ~v[14];            // Final block
  for (int r = 0; r < 12; r++) begin
    for (int g = 0; g < 8; g++) begin
      g4 = g % 4;
      a  = g4;
      if (g < 4) begin
        b = 4 + g4;  // Columns
        c = 8 + g4;
        d = 12 + g4;
      end else begin
        b = 4 + (g4 + 1) % 4;  // Diagonals
        c = 8 + (g4 + 2) % 4;
        d = 12 + (g4 + 3) % 4;
      end
      v[a] = v[a] + v[b] + m[ref_sigma(r, 2*g)];
      v[d] = rotr64(v[d] ^ v[a], 32);
      v[c] = v[c] + v[d];
      v[b] = rotr64(v[b] ^ v[c], 24);
      v[a] = v[a] + v[b] + m[ref_sigma(r, 2*g + 1)];
      v[d] = rotr64(v[d] ^ v[a], 16);
      v[c] = v[c] + v[d];
      v[b] = rotr64(v[b] ^ v[c], 63);
    end
  end
  for (int i = 0; i < 8; i++) begin
    dig[64*i +: 64] = h[i] ^ v[i] ^ v[i+8];
  end
  return dig;
endfunction

`endif

// ==== tb_blake2b.sv ====
// Testbench for the BLAKE2b hash engine
// Random messages and back-pressure, digests checked in order against a model
`timescale 1ns/1ps
`default_nettype none

module tb_blake2b;

  localparam int TAG_W      = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 200;  // Cycles allowed for any single wait

  logic             clk;
  logic             rst;
  logic             blk_valid;
  logic [1023:0]    blk_data;
  logic [7:0]       byte_len;
  logic [511:0]     params;
  logic [TAG_W-1:0] blk_tag;
  logic             blk_ready;
  logic             hash_valid;
  logic [511:0]     hash;
  logic [TAG_W-1:0] hash_tag;
  logic             hash_ready;

  logic [31:0]      lfsr_state;
  logic [511:0]     exp_hash_q [$];  // Scoreboard, acceptance order
  logic [TAG_W-1:0] exp_tag_q  [$];
  int               ready_mode;      // 0 ready, 1 random, 2 held low, 3 one pop then low
  string            test_name;

  `include "tb_blake2b_model.svh"

  blake2b_pipe_top #(
    .TAG_W      (TAG_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_blk_valid  (blk_valid),
    .i_blk_data   (blk_data),
    .i_byte_len   (byte_len),
    .i_params     (params),
    .i_blk_tag    (blk_tag),
    .o_blk_ready  (blk_ready),
    .o_hash_valid (hash_valid),
    .o_hash       (hash),
    .o_hash_tag   (hash_tag),
    .i_hash_ready (hash_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string what, input logic [511:0] exp, input logic [511:0] act);
    if (exp !== act) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // Advance to just after the next rising edge and drive the consumer ready
  task automatic next_cycle();
    @(posedge clk);
    #1;
    case (ready_mode)
      0: hash_ready = 1'b1;
      1: hash_ready = (rand_bits(1) != 32'd0);
      3: begin
        hash_ready = 1'b1;
        ready_mode = 2;  // Exactly one edge of ready
      end
      default: hash_ready = 1'b0;
    endcase
  endtask

  // RFC 7693 digest of "abc", first listed byte is digest byte 0
  function automatic logic [511:0] abc_digest();
    logic [511:0] rfc;
    logic [511:0] d;
    rfc = {256'hba80a53f981c4d0d6a2797b69f12f6e94c212f14685ac4b74b12bb6fdbffa2d1,
           256'h7d87c5392aab792dc252d5de4533cc9518d38aa8dbf1925ab92386edd4009923};
    for (int i = 0; i < 64; i++) begin
      d[8*i +: 8] = rfc[8*(63-i) +: 8];
    end
    return d;
  endfunction

  task automatic load_random(input bit vary_params);
    for (int i = 0; i < 128; i++) begin
      blk_data[8*i +: 8] = 8'(rand_bits(8));  // Bytes past the length stay random
    end
    byte_len      = 8'(rand_bits(8) % 32'd129);
    params        = '0;
    params[31:0]  = 32'h01010040;
    if (vary_params) begin
      params[7:0]   = 8'(rand_bits(6) + 32'd1);  // Digest length 1..64
      params[23:16] = 8'(rand_bits(8));          // Fanout
      params[31:24] = 8'(rand_bits(8));          // Depth
      for (int i = 256; i < 512; i += 32) begin
        params[i +: 32] = rand_bits(32);         // Salt and personalization
      end
    end
    blk_tag = TAG_W'(rand_bits(TAG_W));
  endtask

  task automatic expect_digest(input logic [511:0] exp, input logic [TAG_W-1:0] tag);
    exp_hash_q.push_back(exp);
    exp_tag_q.push_back(tag);
  endtask

  // Present the current inputs until accepted, returns just after the accept edge
  task automatic send_msg(input logic [511:0] exp);
    int waited;
    waited    = 0;
    blk_valid = 1'b1;
    @(negedge clk);
    while (!blk_ready) begin
      if (waited == TIMEOUT) abort_run("timeout waiting for the engine to take a message");
      waited++;
      next_cycle();
      @(negedge clk);
    end
    expect_digest(exp, blk_tag);
    next_cycle();
    blk_valid = 1'b0;
  endtask

  // Valid held high for a fixed window, new message after each accept
  task automatic hold_valid(input int cycles, output int count);
    count = 0;
    load_random(1'b0);
    blk_valid = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      if (blk_ready) begin
        expect_digest(ref_blake2b(blk_data, int'(byte_len), params), blk_tag);
        count++;
        next_cycle();
        load_random(1'b0);
      end else begin
        next_cycle();
      end
    end
    blk_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_hash_q.size() != 0) begin
      if (waited == TIMEOUT) abort_run("timeout waiting for outstanding digests");
      waited++;
      next_cycle();
    end
  endtask

  // Output transfers happen on the following rising edge
  always @(negedge clk) begin
    if (!rst && hash_valid && hash_ready) begin
      if (exp_hash_q.size() == 0) begin
        abort_run("digest delivered with no message outstanding");
      end else begin
        check_val("digest", exp_hash_q.pop_front(), hash);
        check_val("tag", 512'(exp_tag_q.pop_front()), 512'(hash_tag));
      end
    end
  end

  initial begin
    int latency;
    int accepted;
    int gap;
    lfsr_state = 32'hb2c89c2e;
    rst        = 1'b1;
    blk_valid  = 1'b0;
    blk_data   = '0;
    byte_len   = '0;
    params     = '0;
    blk_tag    = '0;
    hash_ready = 1'b0;
    ready_mode = 0;
    test_name  = "reset";
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("o_hash_valid", 512'(0), 512'(hash_valid));
    check_val("o_blk_ready", 512'(1), 512'(blk_ready));

    test_name       = "abc";
    blk_data[23:0]  = 24'h636261;
    byte_len        = 8'd3;
    params[31:0]    = 32'h01010040;  // 64-byte digest, fanout 1, depth 1
    blk_tag         = 8'h5a;
    check_val("model", abc_digest(), ref_blake2b(blk_data, 3, params));
    send_msg(abc_digest());
    latency = 1;  // Edges since accept at which hash_valid is seen
    while (!hash_valid) begin
      if (latency == TIMEOUT) abort_run("timeout waiting for the first digest");
      latency++;
      next_cycle();
    end
    check_val("latency", 512'(27), 512'(latency));
    wait_drain();

    test_name = "random";
    for (int n = 0; n < 200; n++) begin
      load_random(1'b0);
      send_msg(ref_blake2b(blk_data, int'(byte_len), params));
      gap = int'(rand_bits(2));
      repeat (gap) next_cycle();
    end
    wait_drain();

    test_name = "params";
    for (int n = 0; n < 50; n++) begin
      load_random(1'b1);
      send_msg(ref_blake2b(blk_data, int'(byte_len), params));
    end
    wait_drain();

    test_name  = "backpressure";
    ready_mode = 1;
    for (int n = 0; n < 100; n++) begin
      load_random(1'b0);
      send_msg(ref_blake2b(blk_data, int'(byte_len), params));
    end
    ready_mode = 0;
    wait_drain();
    // FIFO must be empty once every expected digest came out
    check_val("o_hash_valid after drain", 512'(0), 512'(hash_valid));

    test_name  = "credits";
    ready_mode = 2;
    next_cycle();
    hold_valid(40, accepted);
    check_val("accepts while stalled", 512'(FIFO_DEPTH), 512'(accepted));
    check_val("o_blk_ready when full", 512'(0), 512'(blk_ready));
    ready_mode = 3;
    hold_valid(10, accepted);
    check_val("accepts after one pop", 512'(1), 512'(accepted));
    ready_mode = 0;
    wait_drain();

    if (exp_hash_q.size() == 0 && exp_tag_q.size() == 0 && !hash_valid) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("digests left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== blake2b_pipe_top.sv ====
// BLAKE2b hash engine top level
// Ingress, unrolled round pipeline and digest FIFO
`timescale 1ns/1ps
`default_nettype none

module blake2b_pipe_top
  import blake2b_pkg::*;
#(
  parameter int TAG_W      = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  wire              i_clk,
  input  wire              i_rst,
  // Message side
  input  wire              i_blk_valid,
  input  wire b2b_block_t  i_blk_data,
  input  wire b2b_len_t    i_byte_len,
  input  wire b2b_hash_t   i_params,
  input  wire [TAG_W-1:0]  i_blk_tag,
  output logic             o_blk_ready,
  // Digest side
  output logic             o_hash_valid,
  output b2b_hash_t        o_hash,
  output logic [TAG_W-1:0] o_hash_tag,
  input  wire              i_hash_ready
);

  logic             ing_valid;  // Ingress to round pipeline
  b2b_hash_t        ing_h;
  b2b_vec_t         ing_v;
  b2b_block_t       ing_msg;
  logic [TAG_W-1:0] ing_tag;
  logic             fin_valid;  // Round pipeline to FIFO
  b2b_hash_t        fin_hash;
  logic [TAG_W-1:0] fin_tag;
  logic             fifo_credit;

  blake2b_ingress #(
    .TAG_W      (TAG_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ingress (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_blk_valid (i_blk_valid),
    .i_blk_data  (i_blk_data),
    .i_byte_len  (i_byte_len),
    .i_params    (i_params),
    .i_blk_tag   (i_blk_tag),
    .o_blk_ready (o_blk_ready),
    .i_credit    (fifo_credit),
    .o_valid     (ing_valid),
    .o_h         (ing_h),
    .o_v         (ing_v),
    .o_msg       (ing_msg),
    .o_tag       (ing_tag)
  );

  blake2b_round_pipe #(
    .TAG_W (TAG_W)
  ) u_rounds (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (ing_valid),
    .i_h     (ing_h),
    .i_v     (ing_v),
    .i_msg   (ing_msg),
    .i_tag   (ing_tag),
    .o_valid (fin_valid),
    .o_hash  (fin_hash),
    .o_tag   (fin_tag)
  );

  blake2b_digest_fifo #(
    .TAG_W      (TAG_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_push       (fin_valid),  // Slot already reserved by a credit
    .i_hash       (fin_hash),
    .i_tag        (fin_tag),
    .o_hash_valid (o_hash_valid),
    .o_hash       (o_hash),
    .o_hash_tag   (o_hash_tag),
    .i_hash_ready (i_hash_ready),
    .o_credit     (fifo_credit)
  );

endmodule

`default_nettype wire

// ==== blake2b_digest_fifo.sv ====
// Show-ahead digest FIFO with tag
// Returns one credit to the ingress per pop
`timescale 1ns/1ps
`default_nettype none

module blake2b_digest_fifo
  import blake2b_pkg::*;
#(
  parameter int TAG_W      = 8,
  parameter int FIFO_DEPTH = 4   // Power of two, at least 2
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_push,
  input  wire b2b_hash_t   i_hash,
  input  wire [TAG_W-1:0]  i_tag,
  output logic             o_hash_valid,
  output b2b_hash_t        o_hash,
  output logic [TAG_W-1:0] o_hash_tag,
  input  wire              i_hash_ready,
  output logic             o_credit
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  b2b_hash_t        hash_mem [FIFO_DEPTH];
  logic [TAG_W-1:0] tag_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;  // Wraps naturally at the depth
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;
  logic             full;

  assign o_hash_valid = (count != '0);
  assign full         = (count == CNT_W'(FIFO_DEPTH));
  assign pop          = o_hash_valid && i_hash_ready;
  assign o_credit     = pop;               // Single cycle per pop
  assign o_hash       = hash_mem[rd_ptr];  // Head entry shown directly
  assign o_hash_tag   = tag_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      hash_mem[wr_ptr] <= i_hash;
      tag_mem[wr_ptr]  <= i_tag;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)    rd_ptr <= rd_ptr + 1'b1;
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Ingress credits must keep the pipeline from pushing into a full buffer
  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
    i_push |-> !full)
    else $error("digest pushed into full FIFO");

endmodule

`default_nettype wire

// ==== blake2b_ingress.sv ====
// Message ingress, byte masking and work vector setup
// Credit counter tracking free digest FIFO slots
`timescale 1ns/1ps
`default_nettype none

module blake2b_ingress
  import blake2b_pkg::*;
#(
  parameter int TAG_W      = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_blk_valid,
  input  wire b2b_block_t  i_blk_data,
  input  wire b2b_len_t    i_byte_len,
  input  wire b2b_hash_t   i_params,   // 64-byte parameter block
  input  wire [TAG_W-1:0]  i_blk_tag,
  output logic             o_blk_ready,
  input  wire              i_credit,   // One slot freed by a FIFO pop
  output logic             o_valid,
  output b2b_hash_t        o_h,
  output b2b_vec_t         o_v,
  output b2b_block_t       o_msg,
  output logic [TAG_W-1:0] o_tag
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CNT_W-1:0] credits;     // Slots not yet claimed by a message
  logic             accept;
  b2b_block_t       msg_masked;
  b2b_hash_t        h_init;

  assign o_blk_ready = (credits != '0);  // Never accept without a reserved slot
  assign accept      = i_blk_valid && o_blk_ready;
  assign h_init      = i_params ^ IV;

  // Bytes past the length are padding and must be zero
  always_comb begin
    for (int b = 0; b < 128; b++) begin
      msg_masked[8*b +: 8] = (b < int'(i_byte_len)) ? i_blk_data[8*b +: 8] : 8'h00;
    end
  end

  // Payload loads only on accept
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_h   <= h_init;
      o_msg <= msg_masked;
      o_tag <= i_blk_tag;
      // v[12] takes the byte count, v[14] inverted as the final block flag
      o_v   <= {IV[7], ~IV[6], IV[5], IV[4] ^ b2b_word_t'(i_byte_len),
                IV[3], IV[2], IV[1], IV[0], h_init};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= accept;
    end
  end

  // Accept and credit return in one cycle cancel out
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      credits <= CNT_W'(FIFO_DEPTH);
    end else begin
      case ({accept, i_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Only pops of digests this side accepted may return credits
  a_credit_max: assert property (@(posedge i_clk) disable iff (i_rst)
    credits <= CNT_W'(FIFO_DEPTH))
    else $error("credit count above FIFO depth");

endmodule

`default_nettype wire

// ==== blake2b_round_pipe.sv ====
// Fully unrolled BLAKE2b compression, 12 rounds as 24 half-round stages
// Finalization stage folds the work vector into the chain value
`timescale 1ns/1ps
`default_nettype none

module blake2b_round_pipe
  import blake2b_pkg::*;
#(
  parameter int TAG_W = 8
) (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire             i_valid,
  input  wire b2b_hash_t  i_h,
  input  wire b2b_vec_t   i_v,
  input  wire b2b_block_t i_msg,
  input  wire [TAG_W-1:0] i_tag,
  output logic            o_valid,
  output b2b_hash_t       o_hash,
  output logic [TAG_W-1:0] o_tag
);

  localparam int NUM_STAGES = 2 * NUM_ROUNDS;  // Column and diagonal half per round

  // Stage outputs, index s is the register bank after stage s
  b2b_vec_t         v_st   [NUM_STAGES];
  b2b_hash_t        h_st   [NUM_STAGES];
  b2b_block_t       m_st   [NUM_STAGES-1];  // Not needed past the last G stage
  logic [TAG_W-1:0] t_st   [NUM_STAGES];
  logic             vld_st [NUM_STAGES];

  for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
    localparam int RND  = s / 2;
    localparam int HALF = s % 2;  // 0 column, 1 diagonal

    b2b_vec_t         v_in;
    b2b_hash_t        h_in;
    b2b_block_t       m_in;
    logic [TAG_W-1:0] t_in;
    logic             vld_in;
    b2b_word_t        v_out [16];  // Work vector words out of the four Gs

    // Stage 0 takes the ingress registers directly
    if (s == 0) begin : g_src
      assign v_in   = i_v;
      assign h_in   = i_h;
      assign m_in   = i_msg;
      assign t_in   = i_tag;
      assign vld_in = i_valid;
    end else begin : g_src
      assign v_in   = v_st[s-1];
      assign h_in   = h_st[s-1];
      assign m_in   = m_st[s-1];
      assign t_in   = t_st[s-1];
      assign vld_in = vld_st[s-1];
    end

    // Four independent Gs, each touches a disjoint set of four words
    for (genvar g = 0; g < 4; g++) begin : g_mix
      localparam int BASE = 16 * HALF + 4 * g;  // Into G_MAPPING
      localparam int MIDX = 8 * HALF + 2 * g;   // Into the SIGMA row

      blake2b_g u_g (
        .i_clk (i_clk),
        .i_a   (v_in[64 * G_MAPPING[BASE + 0] +: 64]),
        .i_b   (v_in[64 * G_MAPPING[BASE + 1] +: 64]),
        .i_c   (v_in[64 * G_MAPPING[BASE + 2] +: 64]),
        .i_d   (v_in[64 * G_MAPPING[BASE + 3] +: 64]),
        .i_m0  (m_in[64 * SIGMA[RND % 10][MIDX] +: 64]),
        .i_m1  (m_in[64 * SIGMA[RND % 10][MIDX + 1] +: 64]),
        .o_a   (v_out[G_MAPPING[BASE + 0]]),
        .o_b   (v_out[G_MAPPING[BASE + 1]]),
        .o_c   (v_out[G_MAPPING[BASE + 2]]),
        .o_d   (v_out[G_MAPPING[BASE + 3]])
      );
    end

    always_comb begin
      for (int w = 0; w < 16; w++) begin
        v_st[s][64*w +: 64] = v_out[w];  // Repack G outputs
      end
    end

    // Side-band travels in step with the G registers
    always_ff @(posedge i_clk) begin
      h_st[s] <= h_in;
      t_st[s] <= t_in;
    end

    if (s < NUM_STAGES - 1) begin : g_msg
      always_ff @(posedge i_clk) begin
        m_st[s] <= m_in;
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        vld_st[s] <= 1'b0;
      end else begin
        vld_st[s] <= vld_in;
      end
    end
  end

  // Finalization, h[i] ^ v[i] ^ v[i+8]
  always_ff @(posedge i_clk) begin
    for (int w = 0; w < 8; w++) begin
      o_hash[64*w +: 64] <= h_st[NUM_STAGES-1][64*w +: 64]
                          ^ v_st[NUM_STAGES-1][64*w +: 64]
                          ^ v_st[NUM_STAGES-1][64*(w+8) +: 64];
    end
    o_tag <= t_st[NUM_STAGES-1];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= vld_st[NUM_STAGES-1];
    end
  end

endmodule

`default_nettype wire

// ==== blake2b_g.sv ====
// BLAKE2b G mixing function on four words
// Whole G evaluated in one cycle, outputs registered
`timescale 1ns/1ps
`default_nettype none

module blake2b_g
  import blake2b_pkg::*;
(
  input  wire       i_clk,
  input  wire b2b_word_t i_a,
  input  wire b2b_word_t i_b,
  input  wire b2b_word_t i_c,
  input  wire b2b_word_t i_d,
  input  wire b2b_word_t i_m0,  // Message word x
  input  wire b2b_word_t i_m1,  // Message word y
  output b2b_word_t o_a,
  output b2b_word_t o_b,
  output b2b_word_t o_c,
  output b2b_word_t o_d
);

  b2b_word_t a1, b1, c1, d1;  // After first half of the mix
  b2b_word_t a2, b2, c2, d2;  // After second half

  function automatic b2b_word_t rotr(input b2b_word_t x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  always_comb begin
    a1 = i_a + i_b + i_m0;
    d1 = rotr(i_d ^ a1, 32);
    c1 = i_c + d1;
    b1 = rotr(i_b ^ c1, 24);
    a2 = a1 + b1 + i_m1;
    d2 = rotr(d1 ^ a2, 16);
    c2 = c1 + d2;
    b2 = rotr(b1 ^ c2, 63);
  end

  // Data only, stage valid is tracked by the round pipeline
  always_ff @(posedge i_clk) begin
    o_a <= a2;
    o_b <= b2;
    o_c <= c2;
    o_d <= d2;
  end

endmodule

`default_nettype wire

// ==== blake2b_pkg.sv ====
// BLAKE2b constants, message schedule and G word mapping
// Width typedefs shared by the hash pipeline
`default_nettype none

package blake2b_pkg;

  typedef logic [63:0]   b2b_word_t;   // One state or message word
  typedef logic [511:0]  b2b_hash_t;   // Chain value or digest, word 0 in the low bits
  typedef logic [1023:0] b2b_vec_t;    // Local work vector v[0..15]
  typedef logic [1023:0] b2b_block_t;  // Message block, byte 0 in bits 7:0
  typedef logic [7:0]    b2b_len_t;    // Byte count, 0 to 128

  localparam int NUM_ROUNDS = 12;

  // Initialization vector, word 0 at index 0
  localparam logic [7:0][63:0] IV = {
    64'h5be0cd19137e2179,
    64'h1f83d9abfb41bd6b,
    64'h9b05688c2b3e6c1f,
    64'h510e527fade682d1,
    64'ha54ff53a5f1d36f1,
    64'h3c6ef372fe94f82b,
    64'hbb67ae8584caa73b,
    64'h6a09e667f3bcc908
  };

  // Message word schedule, one row per round, rounds 10 and 11 reuse rows 0 and 1
  // Each hex digit is one message word index, leftmost digit is entry 0
  localparam logic [0:9][0:15][3:0] SIGMA = {
    64'h0123456789abcdef,
    64'hea489fd61c02b753,
    64'hb8c052fdae367194,
    64'h7931dcbe265a40f8,
    64'h905724afe1bc683d,
    64'h2c6a0b834d75fe19,
    64'hc51fed4a0763928b,
    64'hdb7ec13950f4862a,
    64'h6fe9b308c2d714a5,
    64'ha2847615fb9e3cd0
  };

  // Work vector indices a,b,c,d for each G
  // Entries 0..15 are the four column Gs, 16..31 the four diagonal Gs
  localparam logic [0:31][3:0] G_MAPPING = {
    16'h048c,  // Column 0
    16'h159d,  // Column 1
    16'h26ae,  // Column 2
    16'h37bf,  // Column 3
    16'h05af,  // Diagonal 0
    16'h16bc,  // Diagonal 1
    16'h278d,  // Diagonal 2
    16'h349e   // Diagonal 3
  };

endpackage

`default_nettype wire
